// ==== design/vwrite_pkg.sv ====
package vwrite_pkg;

   localparam int DATA_W     = 32;
   // top bit selects the ping-pong half
   localparam int ADDR_W     = 10;
   localparam int PERIOD_W   = 8;
   localparam int LEN_W      = 8;
   localparam int AXI_ADDR_W = 32;
   localparam int DELAY_W    = 6;

   // settings of one address generator
   typedef struct packed {
      logic [ADDR_W-1:0]   start;
      logic [PERIOD_W-1:0] per;
      logic [PERIOD_W-1:0] duty;
      logic [ADDR_W-1:0]   incr;
      logic [ADDR_W-1:0]   iter;
      logic [ADDR_W-1:0]   shift;
      logic [DELAY_W-1:0]  delay;
   } gen_cfg_t;

   typedef struct packed {
      gen_cfg_t              store_gen;
      gen_cfg_t              read_gen;
      logic [AXI_ADDR_W-1:0] ext_addr;
      logic [AXI_ADDR_W-1:0] addr_shift;
      // words per run, split into bursts of at most length words
      logic [ADDR_W-1:0]     amount;
      logic [LEN_W-1:0]      length;
      logic                  enabled;
   } lane_cfg_t;

   typedef struct packed {
      logic                  valid;
      logic [AXI_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     wdata;
      // word count of the burst
      logic [LEN_W-1:0]      len;
      // high during the final burst of a run
      logic                  last_hint;
   } bus_req_t;

   typedef enum logic [1:0] {IDLE, ADDR, DATA, DONE} writer_state_e;

   typedef enum logic {FREE, LOCKED} arb_state_e;

endpackage

// ==== design/addr_gen.sv ====
`timescale 1ns/1ps

module addr_gen (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          run_i,
   input  vwrite_pkg::gen_cfg_t          cfg_i,
   input  logic                          ready_i,
   output logic                          valid_o,
   output logic [vwrite_pkg::ADDR_W-1:0] addr_o,
   output logic                          done_o
);

   logic                            busy_q;
   logic                            done_q;
   logic [vwrite_pkg::DELAY_W-1:0]  delay_cnt;
   logic [vwrite_pkg::PERIOD_W-1:0] per_cnt;
   logic [vwrite_pkg::ADDR_W-1:0]   iter_cnt;
   logic [vwrite_pkg::ADDR_W-1:0]   addr_q;
   logic [vwrite_pkg::ADDR_W-1:0]   base_q;
   logic                            cfg_ok;
   logic                            in_delay;
   logic                            in_duty;
   logic                            step;
   logic                            per_end;
   logic                            iter_end;

   // zero period or zero iterations means nothing to generate
   assign cfg_ok   = (cfg_i.per != '0) && (cfg_i.iter != '0);
   assign in_delay = (delay_cnt != '0);
   assign in_duty  = (per_cnt < cfg_i.duty);
   assign per_end  = (per_cnt == cfg_i.per - 1'b1);
   assign iter_end = (iter_cnt == cfg_i.iter - 1'b1);

   assign valid_o = busy_q && !in_delay && in_duty;
   // slots outside the duty window advance without a handshake
   assign step    = busy_q && !in_delay && (!in_duty || ready_i);
   assign addr_o  = addr_q;
   assign done_o  = done_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy_q    <= 1'b0;
         done_q    <= 1'b1;
         delay_cnt <= '0;
         per_cnt   <= '0;
         iter_cnt  <= '0;
         addr_q    <= '0;
         base_q    <= '0;
      end else if (run_i) begin
         busy_q    <= cfg_ok;
         done_q    <= !cfg_ok;
         delay_cnt <= cfg_i.delay;
         per_cnt   <= '0;
         iter_cnt  <= '0;
         addr_q    <= cfg_i.start;
         base_q    <= cfg_i.start;
      end else if (busy_q && in_delay) begin
         delay_cnt <= delay_cnt - 1'b1;
      end else if (step) begin
         if (per_end) begin
            // next period starts at the previous base plus shift
            per_cnt <= '0;
            addr_q  <= base_q + cfg_i.shift;
            base_q  <= base_q + cfg_i.shift;
            if (iter_end) begin
               busy_q <= 1'b0;
               done_q <= 1'b1;
            end else begin
               iter_cnt <= iter_cnt + 1'b1;
            end
         end else begin
            per_cnt <= per_cnt + 1'b1;
            if (in_duty) begin
               addr_q <= addr_q + cfg_i.incr;
            end
         end
      end
   end

endmodule

// ==== design/burst_writer.sv ====
`timescale 1ns/1ps

module burst_writer (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              run_i,
   input  logic                              enabled_i,
   input  logic [vwrite_pkg::AXI_ADDR_W-1:0] ext_addr_i,
   input  logic [vwrite_pkg::AXI_ADDR_W-1:0] addr_shift_i,
   input  logic [vwrite_pkg::ADDR_W-1:0]     amount_i,
   input  logic [vwrite_pkg::LEN_W-1:0]      length_i,
   input  logic                              data_valid_i,
   input  logic [vwrite_pkg::DATA_W-1:0]     data_i,
   output logic                              data_ready_o,
   output vwrite_pkg::bus_req_t              bus_req_o,
   input  logic                              grant_i,
   input  logic                              bus_ready_i,
   input  logic                              bus_last_i,
   output logic                              done_o
);

   vwrite_pkg::writer_state_e           state_q;
   logic [vwrite_pkg::AXI_ADDR_W-1:0]   burst_addr_q;
   logic [vwrite_pkg::ADDR_W-1:0]       remaining_q;
   logic [vwrite_pkg::LEN_W-1:0]        cur_len_q;
   logic [vwrite_pkg::LEN_W-1:0]        eff_len;
   logic                                beat;

   // a zero length would never finish, treat it as single-word bursts
   assign eff_len = (length_i == '0) ? vwrite_pkg::LEN_W'(1) : length_i;

   assign data_ready_o = (state_q == vwrite_pkg::DATA) && grant_i && bus_ready_i;
   assign beat         = data_valid_i && data_ready_o;

   assign bus_req_o.valid     = (state_q == vwrite_pkg::DATA) && data_valid_i;
   assign bus_req_o.addr      = burst_addr_q;
   assign bus_req_o.wdata     = data_i;
   assign bus_req_o.len       = cur_len_q;
   assign bus_req_o.last_hint = (remaining_q == vwrite_pkg::ADDR_W'(cur_len_q));

   assign done_o = (state_q == vwrite_pkg::IDLE) || (state_q == vwrite_pkg::DONE);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q      <= vwrite_pkg::IDLE;
         burst_addr_q <= '0;
         remaining_q  <= '0;
         cur_len_q    <= '0;
      end else if (run_i) begin
         burst_addr_q <= ext_addr_i;
         remaining_q  <= amount_i;
         if (enabled_i && amount_i != '0) begin
            state_q <= vwrite_pkg::ADDR;
         end else begin
            state_q <= vwrite_pkg::DONE;
         end
      end else begin
         case (state_q)
            vwrite_pkg::ADDR: begin
               // size of the next burst
               if (remaining_q > vwrite_pkg::ADDR_W'(eff_len)) begin
                  cur_len_q <= eff_len;
               end else begin
                  cur_len_q <= vwrite_pkg::LEN_W'(remaining_q);
               end
               state_q <= vwrite_pkg::DATA;
            end
            vwrite_pkg::DATA: begin
               // slave marks the final beat with last
               if (beat && bus_last_i) begin
                  remaining_q  <= remaining_q - vwrite_pkg::ADDR_W'(cur_len_q);
                  burst_addr_q <= burst_addr_q + addr_shift_i;
                  if (bus_req_o.last_hint) begin
                     state_q <= vwrite_pkg::DONE;
                  end else begin
                     state_q <= vwrite_pkg::ADDR;
                  end
               end
            end
            default: begin
               state_q <= state_q;
            end
         endcase
      end
   end

endmodule

// ==== design/vwrite_lane.sv ====
`timescale 1ns/1ps

module vwrite_lane (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          run_i,
   input  logic                          ping_pong_i,
   input  logic                          half_i,
   input  vwrite_pkg::lane_cfg_t         cfg_i,
   input  logic [vwrite_pkg::DATA_W-1:0] sample_i,
   input  logic                          sample_valid_i,
   output vwrite_pkg::bus_req_t          bus_req_o,
   input  logic                          grant_i,
   input  logic                          bus_ready_i,
   input  logic                          bus_last_i,
   output logic                          done_o
);

   localparam int AW = vwrite_pkg::ADDR_W;

   logic [vwrite_pkg::DATA_W-1:0] buf_mem [2**AW];

   logic                          st_valid;
   logic                          st_done;
   logic                          st_we;
   logic [AW-1:0]                 st_addr_raw;
   logic [AW-1:0]                 st_addr;
   logic                          rd_valid;
   logic                          rd_ready;
   logic                          rd_fire;
   logic [AW-1:0]                 rd_addr_raw;
   logic [AW-1:0]                 rd_addr;
   logic                          mem_valid;
   logic                          skid_valid;
   logic [vwrite_pkg::DATA_W-1:0] mem_data;
   logic [vwrite_pkg::DATA_W-1:0] skid_data;
   logic                          out_valid;
   logic                          out_ready;
   logic [vwrite_pkg::DATA_W-1:0] out_data;
   logic                          wr_done;

   // store side never stalls
   addr_gen store_gen_i (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i),
      .cfg_i   (cfg_i.store_gen),
      .ready_i (1'b1),
      .valid_o (st_valid),
      .addr_o  (st_addr_raw),
      .done_o  (st_done)
   );

   addr_gen read_gen_i (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i && cfg_i.enabled),
      .cfg_i   (cfg_i.read_gen),
      .ready_i (rd_ready),
      .valid_o (rd_valid),
      .addr_o  (rd_addr_raw),
      .done_o  ()
   );

   // with ping-pong on, store and read use opposite halves
   assign st_addr = {ping_pong_i ? half_i : st_addr_raw[AW-1], st_addr_raw[AW-2:0]};
   assign rd_addr = {ping_pong_i ? ~half_i : rd_addr_raw[AW-1], rd_addr_raw[AW-2:0]};
   assign st_we   = st_valid && sample_valid_i;

   // new reads only while the skid register is empty
   assign rd_ready  = !skid_valid;
   assign rd_fire   = rd_valid && rd_ready;
   assign out_valid = skid_valid || mem_valid;
   assign out_data  = skid_valid ? skid_data : mem_data;

   always_ff @(posedge clk) begin
      if (st_we) begin
         buf_mem[st_addr] <= sample_i;
      end
      if (rd_fire) begin
         mem_data <= buf_mem[rd_addr];
      end
      if (!skid_valid && mem_valid && !out_ready) begin
         skid_data <= mem_data;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         mem_valid  <= 1'b0;
         skid_valid <= 1'b0;
      end else if (skid_valid) begin
         // skid holds the older word, memory stage waits behind it
         skid_valid <= !out_ready;
      end else begin
         mem_valid  <= rd_fire;
         skid_valid <= mem_valid && !out_ready;
      end
   end

   burst_writer writer_i (
      .clk          (clk),
      .rst          (rst),
      .run_i        (run_i),
      .enabled_i    (cfg_i.enabled),
      .ext_addr_i   (cfg_i.ext_addr),
      .addr_shift_i (cfg_i.addr_shift),
      .amount_i     (cfg_i.amount),
      .length_i     (cfg_i.length),
      .data_valid_i (out_valid),
      .data_i       (out_data),
      .data_ready_o (out_ready),
      .bus_req_o    (bus_req_o),
      .grant_i      (grant_i),
      .bus_ready_i  (bus_ready_i),
      .bus_last_i   (bus_last_i),
      .done_o       (wr_done)
   );

   assign done_o = st_done && wr_done;

endmodule

// ==== design/run_sequencer.sv ====
`timescale 1ns/1ps

module run_sequencer #(
   parameter int NUM_LANES = 4
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 run_i,
   input  logic                 ping_pong_i,
   input  logic [NUM_LANES-1:0] lane_done_i,
   output logic                 lane_run_o,
   output logic                 ping_pong_o,
   output logic                 half_o,
   output logic                 done_o
);

   logic busy_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         lane_run_o  <= 1'b0;
         ping_pong_o <= 1'b0;
         half_o      <= 1'b0;
         busy_q      <= 1'b0;
         done_o      <= 1'b1;
      end else begin
         lane_run_o <= run_i;
         if (run_i) begin
            ping_pong_o <= ping_pong_i;
            // half flips every run, stays at 0 without ping-pong
            half_o      <= ping_pong_i ? ~half_o : 1'b0;
            busy_q      <= 1'b1;
            done_o      <= 1'b0;
         end else if (busy_q && !lane_run_o && (&lane_done_i)) begin
            // lane done flags are stale during the run pulse itself
            busy_q <= 1'b0;
            done_o <= 1'b1;
         end
      end
   end

endmodule

// ==== design/databus_arbiter.sv ====
`timescale 1ns/1ps

module databus_arbiter #(
   parameter int NUM_LANES = 4
) (
   input  logic                              clk,
   input  logic                              rst,
   input  vwrite_pkg::bus_req_t              lane_req_i [NUM_LANES],
   output logic [NUM_LANES-1:0]              grant_o,
   input  logic                              bus_ready_i,
   input  logic                              bus_last_i,
   output logic                              bus_valid_o,
   output logic [vwrite_pkg::AXI_ADDR_W-1:0] bus_addr_o,
   output logic [vwrite_pkg::DATA_W-1:0]     bus_wdata_o,
   output logic [vwrite_pkg::LEN_W-1:0]      bus_len_o
);

   localparam int IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

   vwrite_pkg::arb_state_e state_q;
   logic [IDX_W-1:0]       owner_q;
   logic [IDX_W-1:0]       last_q;
   logic [IDX_W-1:0]       pick;
   logic                   found;
   vwrite_pkg::bus_req_t   win;

   // first requesting lane after the last winner
   always_comb begin
      int unsigned cand;
      found = 1'b0;
      pick  = last_q;
      for (int k = 1; k <= NUM_LANES; k++) begin
         cand = (int'(last_q) + k) % NUM_LANES;
         if (!found && lane_req_i[cand].valid) begin
            found = 1'b1;
            pick  = IDX_W'(cand);
         end
      end
   end

   always_comb begin
      grant_o = '0;
      if (state_q == vwrite_pkg::LOCKED) begin
         grant_o[owner_q] = 1'b1;
      end
   end

   assign win         = lane_req_i[owner_q];
   assign bus_valid_o = (state_q == vwrite_pkg::LOCKED) && win.valid;
   assign bus_addr_o  = win.addr;
   assign bus_wdata_o = win.wdata;
   assign bus_len_o   = win.len;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= vwrite_pkg::FREE;
         owner_q <= '0;
         // lane 0 wins the first round
         last_q  <= IDX_W'(NUM_LANES - 1);
      end else if (state_q == vwrite_pkg::FREE) begin
         if (found) begin
            state_q <= vwrite_pkg::LOCKED;
            owner_q <= pick;
         end
      end else if (bus_valid_o && bus_ready_i && bus_last_i) begin
         state_q <= vwrite_pkg::FREE;
         last_q  <= owner_q;
      end
   end

endmodule

// ==== design/vwrite_array.sv ====
`timescale 1ns/1ps

module vwrite_array #(
   parameter int NUM_LANES = 4
) (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                run_i,
   input  logic                                ping_pong_i,
   input  vwrite_pkg::lane_cfg_t               cfg_i          [NUM_LANES],
   input  logic [vwrite_pkg::DATA_W-1:0]       sample_i       [NUM_LANES],
   input  logic [NUM_LANES-1:0]                sample_valid_i,
   input  logic                                bus_ready_i,
   input  logic                                bus_last_i,
   output logic                                bus_valid_o,
   output logic [vwrite_pkg::AXI_ADDR_W-1:0]   bus_addr_o,
   output logic [vwrite_pkg::DATA_W-1:0]       bus_wdata_o,
   output logic [vwrite_pkg::DATA_W/8-1:0]     bus_wstrb_o,
   output logic [vwrite_pkg::LEN_W-1:0]        bus_len_o,
   output logic                                done_o
);

   logic                 lane_run;
   logic                 ping_pong;
   logic                 half;
   logic [NUM_LANES-1:0] lane_done;
   logic [NUM_LANES-1:0] grant;
   vwrite_pkg::bus_req_t lane_req [NUM_LANES];

   run_sequencer #(
      .NUM_LANES (NUM_LANES)
   ) sequencer_i (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .ping_pong_i (ping_pong_i),
      .lane_done_i (lane_done),
      .lane_run_o  (lane_run),
      .ping_pong_o (ping_pong),
      .half_o      (half),
      .done_o      (done_o)
   );

   for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
      vwrite_lane lane_i (
         .clk            (clk),
         .rst            (rst),
         .run_i          (lane_run),
         .ping_pong_i    (ping_pong),
         .half_i         (half),
         .cfg_i          (cfg_i[l]),
         .sample_i       (sample_i[l]),
         .sample_valid_i (sample_valid_i[l]),
         .bus_req_o      (lane_req[l]),
         .grant_i        (grant[l]),
         .bus_ready_i    (bus_ready_i),
         .bus_last_i     (bus_last_i),
         .done_o         (lane_done[l])
      );
   end

   databus_arbiter #(
      .NUM_LANES (NUM_LANES)
   ) arbiter_i (
      .clk         (clk),
      .rst         (rst),
      .lane_req_i  (lane_req),
      .grant_o     (grant),
      .bus_ready_i (bus_ready_i),
      .bus_last_i  (bus_last_i),
      .bus_valid_o (bus_valid_o),
      .bus_addr_o  (bus_addr_o),
      .bus_wdata_o (bus_wdata_o),
      .bus_len_o   (bus_len_o)
   );

   // full-word writes only
   assign bus_wstrb_o = '1;

endmodule

// ==== verification/vwrite_array_assert.sv ====
`timescale 1ns/1ps

module vwrite_array_assert #(
   parameter int NUM_LANES = 4
) (
   input logic                              clk,
   input logic                              rst,
   input logic                              run_i,
   input logic                              done_o,
   input logic                              bus_valid_o,
   input logic                              bus_ready_i,
   input logic                              bus_last_i,
   input logic [vwrite_pkg::AXI_ADDR_W-1:0] bus_addr_o,
   input logic [vwrite_pkg::LEN_W-1:0]      bus_len_o,
   input logic [NUM_LANES-1:0]              grant
);

   int fail_cnt = 0;

   grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
      else begin
         $error("more than one lane granted");
         fail_cnt++;
      end

   // grant moves only after the beat that carries last
   grant_hold: assert property (@(posedge clk) disable iff (rst)
      (grant != '0) && !(bus_valid_o && bus_ready_i && bus_last_i) |=> $stable(grant))
      else begin
         $error("grant changed inside a burst");
         fail_cnt++;
      end

   hold_until_ready: assert property (@(posedge clk) disable iff (rst)
      bus_valid_o && !bus_ready_i |=> bus_valid_o && $stable(bus_addr_o) && $stable(bus_len_o))
      else begin
         $error("valid, addr or len changed before the transfer");
         fail_cnt++;
      end

   // addr and len belong to the whole burst
   burst_hold: assert property (@(posedge clk) disable iff (rst)
      bus_valid_o && bus_ready_i && !bus_last_i |=> $stable(bus_addr_o) && $stable(bus_len_o))
      else begin
         $error("addr or len changed between beats of one burst");
         fail_cnt++;
      end

   done_falls: assert property (@(posedge clk) disable iff (rst) run_i |=> !done_o)
      else begin
         $error("done did not fall after the run pulse");
         fail_cnt++;
      end

endmodule

bind vwrite_array vwrite_array_assert #(
   .NUM_LANES (NUM_LANES)
) vwrite_array_assert_i (
   .clk         (clk),
   .rst         (rst),
   .run_i       (run_i),
   .done_o      (done_o),
   .bus_valid_o (bus_valid_o),
   .bus_ready_i (bus_ready_i),
   .bus_last_i  (bus_last_i),
   .bus_addr_o  (bus_addr_o),
   .bus_len_o   (bus_len_o),
   .grant       (grant)
);

// ==== verification/vwrite_array_tb.sv ====
`timescale 1ns/1ps

module vwrite_array_tb;

   localparam int          NUM_LANES   = 4;
   localparam logic [31:0] EXT_BASE    = 32'h4000_0000;
   localparam logic [31:0] REGION      = 32'h0000_1000;
   localparam logic [31:0] ADDR_SHIFT  = 32'h0000_0040;
   // words over all six runs with lane 2 off in the last one
   localparam int          TOTAL_WORDS = NUM_LANES * (12 + 12 + 10 + 10 + 10)
                                         + (NUM_LANES - 1) * 10;
   localparam int          WATCHDOG_NS = 4 * TOTAL_WORDS * 8 + 2000;

   logic                                clk;
   logic                                rst;
   logic                                run_i;
   logic                                ping_pong_i;
   vwrite_pkg::lane_cfg_t               cfg_i          [NUM_LANES];
   logic [vwrite_pkg::DATA_W-1:0]       sample_i       [NUM_LANES];
   logic [NUM_LANES-1:0]                sample_valid_i;
   logic                                bus_ready_i;
   logic                                bus_last_i;
   logic                                bus_valid_o;
   logic [vwrite_pkg::AXI_ADDR_W-1:0]   bus_addr_o;
   logic [vwrite_pkg::DATA_W-1:0]       bus_wdata_o;
   logic [vwrite_pkg::DATA_W/8-1:0]     bus_wstrb_o;
   logic [vwrite_pkg::LEN_W-1:0]        bus_len_o;
   logic                                done_o;

   int                   errors     = 0;
   int                   tests      = 0;
   int                   run_no     = 0;
   int                   smp_idx    = 0;
   int                   smp_run    = 0;
   int                   mon_beat   = 0;
   int                   cur_lane   = 0;
   // arbiter starts as if the last lane had just won
   int                   prev_lane  = NUM_LANES - 1;
   int                   cur_amount = 0;
   int                   cur_length = 1;
   int                   words      [NUM_LANES];
   int                   bursts     [NUM_LANES];
   logic [NUM_LANES-1:0] en_mask    = '1;
   logic                 stall_en   = 1'b0;
   logic                 check_data = 1'b0;
   logic [31:0]          rnd        = 32'h8c92f678;

   vwrite_array #(
      .NUM_LANES (NUM_LANES)
   ) vwrite_array_i (
      .clk            (clk),
      .rst            (rst),
      .run_i          (run_i),
      .ping_pong_i    (ping_pong_i),
      .cfg_i          (cfg_i),
      .sample_i       (sample_i),
      .sample_valid_i (sample_valid_i),
      .bus_ready_i    (bus_ready_i),
      .bus_last_i     (bus_last_i),
      .bus_valid_o    (bus_valid_o),
      .bus_addr_o     (bus_addr_o),
      .bus_wdata_o    (bus_wdata_o),
      .bus_wstrb_o    (bus_wstrb_o),
      .bus_len_o      (bus_len_o),
      .done_o         (done_o)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // lane, run and index fields of one sample
   function automatic logic [31:0] make_sample(input int lane, input int run, input int idx);
      return {4'(lane), 8'(run), 20'(idx)};
   endfunction

   function automatic int next_lane(input int prev, input logic [NUM_LANES-1:0] en);
      int cand;
      for (int k = 1; k <= NUM_LANES; k++) begin
         cand = (prev + k) % NUM_LANES;
         if (en[cand]) begin
            return cand;
         end
      end
      return prev;
   endfunction

   function automatic int total_errors();
      return errors + vwrite_array_i.vwrite_array_assert_i.fail_cnt;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // linear pattern of one period of amount words
   task automatic set_config(input int amount, input int length,
                             input logic [NUM_LANES-1:0] en);
      vwrite_pkg::gen_cfg_t gen;
      gen      = '0;
      gen.per  = vwrite_pkg::PERIOD_W'(amount);
      gen.duty = vwrite_pkg::PERIOD_W'(amount);
      gen.incr = vwrite_pkg::ADDR_W'(1);
      gen.iter = vwrite_pkg::ADDR_W'(1);
      for (int l = 0; l < NUM_LANES; l++) begin
         cfg_i[l]            = '0;
         cfg_i[l].store_gen  = gen;
         cfg_i[l].read_gen   = gen;
         cfg_i[l].ext_addr   = EXT_BASE + REGION * l;
         cfg_i[l].addr_shift = ADDR_SHIFT;
         cfg_i[l].amount     = vwrite_pkg::ADDR_W'(amount);
         cfg_i[l].length     = vwrite_pkg::LEN_W'(length);
         cfg_i[l].enabled    = en[l];
      end
   endtask

   task automatic do_run(input int amount, input int length,
                         input logic [NUM_LANES-1:0] en, input logic stall);
      @(posedge clk);
      #1;
      set_config(amount, length, en);
      cur_amount = amount;
      cur_length = length;
      en_mask    = en;
      stall_en   = stall;
      for (int l = 0; l < NUM_LANES; l++) begin
         words[l]  = 0;
         bursts[l] = 0;
      end
      run_no++;
      // the first run reads a half that was never written
      check_data = (run_no > 1);
      run_i      = 1'b1;
      check_value("done_o", done_o, 1'b1);
      @(posedge clk);
      #1;
      run_i = 1'b0;
      check_value("done_o", done_o, 1'b0);
      do begin
         @(posedge clk);
         #1;
      end while (done_o !== 1'b1);
      for (int l = 0; l < NUM_LANES; l++) begin
         check_value("lane word count", words[l], en[l] ? amount : 0);
         check_value("lane burst count", bursts[l], en[l] ? (amount + length - 1) / length : 0);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      int errs;
      errs = total_errors() - errs_before;
      tests++;
      if (errs == 0) begin
         $display("test %0d %s: ok", tests, name);
      end else begin
         $display("test %0d %s: %0d errors", tests, name, errs);
      end
   endtask

   // sample index 0 reaches the store generator's first write
   always @(posedge clk) begin : sample_drive
      if (run_i) begin
         smp_idx = -1;
         smp_run = run_no;
      end else begin
         smp_idx++;
      end
      #1;
      for (int l = 0; l < NUM_LANES; l++) begin
         sample_i[l] = make_sample(l, smp_run, smp_idx);
      end
   end

   // memory side checks every beat, then drives ready and last
   always @(posedge clk) begin : bus_slave
      int          lane;
      int          remaining;
      logic [31:0] exp_len;
      if (!rst && bus_valid_o === 1'b1 && bus_ready_i) begin
         lane = int'(bus_addr_o[15:12]);
         if (lane >= NUM_LANES) begin
            $display("burst at %0t goes to %h, outside every lane region", $time, bus_addr_o);
            errors++;
         end else begin
            if (mon_beat == 0) begin
               check_value("bus_addr_o lane", lane, next_lane(prev_lane, en_mask));
               prev_lane = lane;
               cur_lane  = lane;
               check_value("bus_addr_o", bus_addr_o,
                           EXT_BASE + REGION * lane + ADDR_SHIFT * bursts[lane]);
               remaining = cur_amount - words[lane];
               exp_len   = (remaining < cur_length) ? remaining : cur_length;
               check_value("bus_len_o", bus_len_o, exp_len);
            end else begin
               check_value("bus_addr_o lane", lane, cur_lane);
            end
            if (check_data) begin
               check_value("bus_wdata_o", bus_wdata_o, make_sample(lane, run_no - 1, words[lane]));
            end
            // every byte of every word is written
            check_value("bus_wstrb_o", bus_wstrb_o, {(vwrite_pkg::DATA_W / 8){1'b1}});
            words[lane]++;
            if (bus_last_i) begin
               bursts[lane]++;
            end
         end
         mon_beat = bus_last_i ? 0 : mon_beat + 1;
      end
      #1;
      rnd         = xorshift32(rnd);
      bus_ready_i = !stall_en || (rnd[2:0] > 3'd1);
      bus_last_i  = bus_ready_i && (bus_valid_o === 1'b1)
                    && (mon_beat == int'(bus_len_o) - 1);
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("watchdog expired at %0t, the runs did not complete", $time);
      $display("TESTS FAILED");
      $finish;
   end

   initial begin : main
      int mark;
      rst            = 1'b1;
      run_i          = 1'b0;
      ping_pong_i    = 1'b1;
      sample_valid_i = '1;
      bus_ready_i    = 1'b0;
      bus_last_i     = 1'b0;
      for (int l = 0; l < NUM_LANES; l++) begin
         sample_i[l] = '0;
      end
      set_config(12, 4, '1);
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;

      mark = total_errors();
      check_value("bus_valid_o", bus_valid_o, 1'b0);
      check_value("done_o", done_o, 1'b1);
      do_run(12, 4, '1, 1'b0);
      report_test("reset", mark);

      mark = total_errors();
      do_run(12, 4, '1, 1'b0);
      report_test("ping-pong run pair", mark);

      // 10 words in bursts of 4, 4 and 2
      mark = total_errors();
      do_run(10, 4, '1, 1'b0);
      report_test("burst splitting", mark);

      mark = total_errors();
      do_run(10, 3, '1, 1'b0);
      report_test("arbitration", mark);

      mark = total_errors();
      do_run(10, 4, '1, 1'b1);
      report_test("back-pressure", mark);

      mark = total_errors();
      do_run(10, 4, 4'b1011, 1'b1);
      report_test("disabled lane", mark);

      $display("%0d tests run, %0d errors", tests, total_errors());
      if (total_errors() == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== Bender.yml ====
package:
  name: vwrite_array

sources:
  - design/vwrite_pkg.sv
  - design/addr_gen.sv
  - design/burst_writer.sv
  - design/vwrite_lane.sv
  - design/run_sequencer.sv
  - design/databus_arbiter.sv
  - design/vwrite_array.sv
  - target: simulation
    files:
      - verification/vwrite_array_assert.sv
      - verification/vwrite_array_tb.sv

// ==== vwrite_array.f ====
design/vwrite_pkg.sv
design/addr_gen.sv
design/burst_writer.sv
design/vwrite_lane.sv
design/run_sequencer.sv
design/databus_arbiter.sv
design/vwrite_array.sv
verification/vwrite_array_assert.sv
verification/vwrite_array_tb.sv
